/* filelist.f */
rtl/rv_mem_pkg.sv
rtl/axi_pkg.sv
rtl/lsu_format.sv
rtl/wb_forward.sv
rtl/dcache.sv
rtl/mem_stage.sv
verif/axi_mem_model.sv
verif/tb_mem_stage.sv

/* Makefile */
# Verilator build and run of the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_mem_stage.sv */
/*
 * testbench for the rv64 memory stage
 * issues loads, stores and alu results, mirrors memory in a shadow array
 * and checks every writeback in order against a reference model
 */
`timescale 1ns/1ns

module tb_mem_stage;
    import rv_mem_pkg::*;
    import axi_pkg::*;

    typedef struct packed {
        xlen_t    pc;
        inst_t    inst;
        reg_idx_t rd;
        logic     wen;
        xlen_t    data;
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic ex_valid, ex_rd_wen, ex_ready, wb_valid, wb_ready, rf_wen, fwd_valid;
    xlen_t ex_pc, ex_result, ex_src2, wb_pc, rf_wdata, fwd_wdata;
    inst_t ex_inst, wb_inst, fwd_inst;
    mem_op_t ex_mem_op;
    reg_idx_t rf_waddr;
    axi_addr_t axi_araddr, axi_awaddr;
    axi_data_t axi_rdata, axi_wdata;
    axi_strb_t axi_wstrb;
    logic [7:0] axi_arlen, axi_awlen;
    logic [2:0] axi_arsize, axi_awsize;
    logic [1:0] axi_arburst, axi_awburst, axi_rresp, axi_bresp;
    logic axi_arvalid, axi_arready, axi_rlast, axi_rvalid, axi_rready;
    logic axi_awvalid, axi_awready, axi_wlast, axi_wvalid, axi_wready;
    logic axi_bvalid, axi_bready;

    logic [7:0] shadow [4096];
    exp_t       exp_q [$];
    int         errors = 0;
    int         n_issued = 0;
    int         cycles = 0;
    logic       stall_en = 1'b0;
    xlen_t      pc_next = 64'h1000;
    mem_op_t    load_ops [7] = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD};
    mem_op_t    store_ops [4] = '{MEM_SB, MEM_SH, MEM_SW, MEM_SD};

    always #10 clk = ~clk;

    mem_stage #(.CACHE_LINES(64)) uut (.*);

    axi_mem_model mem_model (
        .clk(clk), .rst(rst),
        .araddr(axi_araddr), .arvalid(axi_arvalid), .arready(axi_arready),
        .rdata(axi_rdata), .rresp(axi_rresp), .rlast(axi_rlast),
        .rvalid(axi_rvalid), .rready(axi_rready),
        .awaddr(axi_awaddr), .awvalid(axi_awvalid), .awready(axi_awready),
        .wdata(axi_wdata), .wstrb(axi_wstrb), .wvalid(axi_wvalid), .wready(axi_wready),
        .bresp(axi_bresp), .bvalid(axi_bvalid), .bready(axi_bready)
    );

    function automatic logic [7:0] fill_byte(logic [11:0] a);
        return 8'((a * 12'd37) ^ (a >> 4));
    endfunction

    function automatic int op_bytes(mem_op_t op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_LWU, MEM_SW: return 4;
            MEM_LD, MEM_SD:          return 8;
            default:                 return 0;
        endcase
    endfunction

    // opcode classes that write rd
    function automatic logic writes_rd(inst_t inst);
        return inst[6:0] inside {7'h03, 7'h13, 7'h17, 7'h1b, 7'h33, 7'h37, 7'h3b};
    endfunction

    function automatic xlen_t load_ref(mem_op_t op, logic [11:0] a);
        xlen_t v;
        v = '0;
        for (int i = 0; i < op_bytes(op); i++) v[8*i +: 8] = shadow[a + 12'(i)];
        case (op)
            MEM_LB:  v = {{56{v[7]}}, v[7:0]};
            MEM_LH:  v = {{48{v[15]}}, v[15:0]};
            MEM_LW:  v = {{32{v[31]}}, v[31:0]};
            default: ;
        endcase
        return v;
    endfunction

    task automatic send(mem_op_t op, xlen_t result, xlen_t src2, reg_idx_t rd, reg_idx_t rs2,
                        logic rd_wen, logic fv, inst_t fi, xlen_t fd);
        exp_t  e;
        xlen_t sdata;
        logic [6:0] opc;
        opc   = is_load(op) ? 7'h03 : (is_store(op) ? 7'h23 : 7'h33);
        sdata = (fv && writes_rd(fi) && fi[11:7] == rs2 && rs2 != 5'd0) ? fd : src2;
        e.pc   = pc_next;
        e.inst = {7'd0, rs2, 5'd1, 3'd0, rd, opc};
        e.rd   = rd;
        e.wen  = rd_wen;
        e.data = is_load(op) ? load_ref(op, result[11:0]) : result;
        if (is_store(op)) begin
            for (int i = 0; i < op_bytes(op); i++) begin
                shadow[result[11:0] + 12'(i)] = sdata[8*i +: 8];
            end
        end
        @(negedge clk);
        ex_valid  = 1'b1;
        ex_pc     = pc_next;
        ex_inst   = e.inst;
        ex_mem_op = op;
        ex_rd_wen = rd_wen;
        ex_result = result;
        ex_src2   = src2;
        do @(posedge clk); while (!ex_ready);
        exp_q.push_back(e);
        n_issued++;
        pc_next += 4;
        // forward inputs belong to the entry now in the stage
        @(negedge clk);
        ex_valid  = 1'b0;
        fwd_valid = fv;
        fwd_inst  = fi;
        fwd_wdata = fd;
    endtask

    task automatic do_load(mem_op_t op, logic [11:0] a);
        send(op, xlen_t'(a), '0, 5'd3, 5'd0, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic do_store(mem_op_t op, logic [11:0] a, xlen_t d);
        send(op, xlen_t'(a), d, 5'd0, 5'd7, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    always @(negedge clk) wb_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;

    always @(posedge clk) begin : compare
        exp_t e;
        if (!rst && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("writeback at pc %h with no instruction outstanding", wb_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                assert (wb_pc == e.pc) else begin
                    $display("mismatch wb_pc: got %h expected %h", wb_pc, e.pc);
                    errors++;
                end
                assert (wb_inst == e.inst) else begin
                    $display("mismatch wb_inst: got %h expected %h", wb_inst, e.inst);
                    errors++;
                end
                assert (rf_waddr == e.rd) else begin
                    $display("mismatch rf_waddr: got %h expected %h", rf_waddr, e.rd);
                    errors++;
                end
                assert (rf_wen == e.wen) else begin
                    $display("mismatch rf_wen: got %h expected %h", rf_wen, e.wen);
                    errors++;
                end
                assert (rf_wdata == e.data) else begin
                    $display("mismatch rf_wdata at pc %h: got %h expected %h",
                             wb_pc, rf_wdata, e.data);
                    errors++;
                end
            end
        end
    end

    // single 8-byte beat per transfer on every channel
    always @(posedge clk) begin
        if (!rst && axi_arvalid) begin
            assert (axi_arlen == 8'h00 && axi_arsize == 3'h3 && axi_arburst == 2'h1) else begin
                $display("mismatch axi_arlen/size/burst: got %h/%h/%h expected 00/3/1",
                         axi_arlen, axi_arsize, axi_arburst);
                errors++;
            end
        end
        if (!rst && axi_awvalid) begin
            assert (axi_awlen == 8'h00 && axi_awsize == 3'h3 && axi_awburst == 2'h1) else begin
                $display("mismatch axi_awlen/size/burst: got %h/%h/%h expected 00/3/1",
                         axi_awlen, axi_awsize, axi_awburst);
                errors++;
            end
        end
        if (!rst && axi_wvalid) begin
            assert (axi_wlast == 1'b1) else begin
                $display("mismatch axi_wlast: got %h expected 1", axi_wlast);
                errors++;
            end
        end
    end

    // 200 cycles per issued instruction
    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * (n_issued + 1)) begin
            $display("timeout after %0d cycles with %0d writebacks pending", cycles, exp_q.size());
            $display("errors: %0d", errors);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int   n_ar;
        int   n_aw;
        int   k;
        xlen_t d;
        logic [11:0] a;
        mem_op_t op;
        void'($urandom(32'hb6f4));
        rst = 1'b1;
        ex_valid = 1'b0;
        ex_pc = '0;
        ex_inst = '0;
        ex_mem_op = MEM_NONE;
        ex_rd_wen = 1'b0;
        ex_result = '0;
        ex_src2 = '0;
        wb_ready = 1'b1;
        fwd_valid = 1'b0;
        fwd_inst = '0;
        fwd_wdata = '0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = fill_byte(12'(i));
            mem_model.mem[i] = fill_byte(12'(i));
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // every load width and sign at each legal offset
        foreach (load_ops[j]) begin
            for (int off = 0; off < 8; off += op_bytes(load_ops[j])) begin
                do_load(load_ops[j], 12'h108 + 12'(off));
            end
        end

        // stores merge into the doubleword, the repeated load hits
        foreach (store_ops[j]) begin
            for (int off = 0; off < 8; off += op_bytes(store_ops[j])) begin
                do_store(store_ops[j], 12'h300 + 12'(off), {$urandom, $urandom});
                do_load(MEM_LD, 12'h300);
                drain();
                n_ar = mem_model.ar_count;
                do_load(MEM_LD, 12'h300);
                drain();
                assert (mem_model.ar_count == n_ar) else begin
                    $display("repeated load of 0x300 caused an AXI read");
                    errors++;
                end
            end
        end

        // store miss goes to memory only
        d = {$urandom, $urandom};
        do_store(MEM_SD, 12'h900, d);
        drain();
        for (int i = 0; i < 8; i++) begin
            assert (mem_model.mem[12'h900 + i] == d[8*i +: 8]) else begin
                $display("mismatch mem[%h]: got %h expected %h",
                         12'h900 + i, mem_model.mem[12'h900 + i], d[8*i +: 8]);
                errors++;
            end
        end
        n_ar = mem_model.ar_count;
        do_load(MEM_LD, 12'h900);
        drain();
        assert (mem_model.ar_count == n_ar + 1) else begin
            $display("load after a store miss made %0d AXI reads instead of one",
                     mem_model.ar_count - n_ar);
            errors++;
        end

        // rs2 forwarding from the writeback register
        send(MEM_SD, 64'ha00, 64'h1111, 5'd0, 5'd5, 1'b0, 1'b1, 32'h2b3, 64'hfeed_beef_0bad_f00d);
        do_load(MEM_LD, 12'ha00);
        send(MEM_SD, 64'ha08, 64'h2222, 5'd0, 5'd5, 1'b0, 1'b1, 32'h2a3, 64'h3333);
        do_load(MEM_LD, 12'ha08);
        send(MEM_SD, 64'ha10, 64'h4444, 5'd0, 5'd0, 1'b0, 1'b1, 32'h033, 64'h5555);
        do_load(MEM_LD, 12'ha10);
        send(MEM_SD, 64'ha18, 64'h6666, 5'd0, 5'd5, 1'b0, 1'b0, 32'h2b3, 64'h7777);
        do_load(MEM_LD, 12'ha18);
        drain();

        // alu results pass through without bus traffic
        n_ar = mem_model.ar_count;
        n_aw = mem_model.aw_count;
        for (int i = 0; i < 6; i++) begin
            send(MEM_NONE, {$urandom, $urandom}, '0, 5'(i + 1), 5'd0, 1'(i), 1'b0, '0, '0);
        end
        drain();
        assert (mem_model.ar_count == n_ar && mem_model.aw_count == n_aw) else begin
            $display("non-memory instructions caused AXI traffic");
            errors++;
        end

        // random mix under writeback stalls
        stall_en = 1'b1;
        repeat (80) begin
            k = $urandom % 3;
            a = 12'(($urandom % 512) * 8);
            if (k == 0) begin
                op = load_ops[$urandom % 7];
                do_load(op, a + 12'(($urandom % 8) & ~(op_bytes(op) - 1)));
            end else if (k == 1) begin
                op = store_ops[$urandom % 4];
                send(op, xlen_t'(a + 12'(($urandom % 8) & ~(op_bytes(op) - 1))),
                     {$urandom, $urandom}, 5'd0, 5'($urandom % 4), 1'b0, 1'($urandom % 2),
                     {20'd0, 5'($urandom % 4), ($urandom % 2) ? 7'h33 : 7'h23},
                     {$urandom, $urandom});
            end else begin
                send(MEM_NONE, {$urandom, $urandom}, '0, 5'($urandom), 5'd0,
                     1'($urandom), 1'b0, '0, '0);
            end
        end
        drain();
        stall_en = 1'b0;
        repeat (5) @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d instructions never reached writeback", exp_q.size());
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verif/axi_mem_model.sv */
/*
 * axi slave memory for the data cache testbench
 * single-beat reads and writes over a 4 KiB byte array,
 * random 0-3 cycle ready delays, outputs change on the falling edge
 */
`timescale 1ns/1ns

module axi_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  axi_pkg::axi_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::axi_data_t rdata,
    output logic [1:0]         rresp,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  axi_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready
);
    import axi_pkg::*;

    logic [7:0] mem [4096];     // filled by the testbench at time zero
    int         ar_count = 0;
    int         aw_count = 0;

    logic      ar_fire;
    logic      r_fire;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;
    axi_addr_t rd_addr;
    axi_addr_t wr_addr;
    axi_data_t wr_data;
    axi_strb_t wr_strb;
    logic      have_aw = 1'b0;
    logic      have_w = 1'b0;
    logic [1:0] ar_dly = 2'd0;
    logic [1:0] aw_dly = 2'd0;
    logic [1:0] w_dly = 2'd0;

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    assign rresp = 2'b00;
    assign rlast = 1'b1;
    assign bresp = 2'b00;

    // handshakes happen on the rising edge
    always @(posedge clk) begin
        ar_fire <= arvalid && arready;
        r_fire  <= rvalid && rready;
        aw_fire <= awvalid && awready;
        w_fire  <= wvalid && wready;
        b_fire  <= bvalid && bready;
        if (arvalid && arready) rd_addr <= araddr;
        if (awvalid && awready) wr_addr <= awaddr;
        if (wvalid && wready) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            have_aw <= 1'b0;
            have_w  <= 1'b0;
        end else begin
            if (ar_fire) begin
                arready  <= 1'b0;
                ar_dly   <= 2'($urandom % 4);
                ar_count <= ar_count + 1;
                rvalid   <= 1'b1;
                for (int i = 0; i < 8; i++) begin
                    rdata[8*i +: 8] <= mem[{rd_addr[11:3], 3'(i)}];
                end
            end else if (arvalid && !arready) begin
                if (ar_dly == 2'd0) arready <= 1'b1;
                else ar_dly <= ar_dly - 2'd1;
            end
            if (r_fire) rvalid <= 1'b0;

            if (aw_fire) begin
                awready  <= 1'b0;
                aw_dly   <= 2'($urandom % 4);
                aw_count <= aw_count + 1;
                have_aw  <= 1'b1;
            end else if (awvalid && !awready) begin
                if (aw_dly == 2'd0) awready <= 1'b1;
                else aw_dly <= aw_dly - 2'd1;
            end
            if (w_fire) begin
                wready <= 1'b0;
                w_dly  <= 2'($urandom % 4);
                have_w <= 1'b1;
            end else if (wvalid && !wready) begin
                if (w_dly == 2'd0) wready <= 1'b1;
                else w_dly <= w_dly - 2'd1;
            end

            // both halves in, commit bytes and answer
            if (have_aw && have_w) begin
                for (int i = 0; i < 8; i++) begin
                    if (wr_strb[i]) mem[{wr_addr[11:3], 3'(i)}] = wr_data[8*i +: 8];
                end
                have_aw <= 1'b0;
                have_w  <= 1'b0;
                bvalid  <= 1'b1;
            end
            if (b_fire) bvalid <= 1'b0;
        end
    end

endmodule

/* rtl/mem_stage.sv */
/*
 * rv64 memory-access stage
 * stage register from execute, store/load formatting, rs2 forwarding,
 * data cache access with stall, writeback and register-file outputs
 */
`timescale 1ns/1ns

module mem_stage #(
    parameter int CACHE_LINES = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  rv_mem_pkg::xlen_t    ex_pc,
    input  rv_mem_pkg::inst_t    ex_inst,
    input  rv_mem_pkg::mem_op_t  ex_mem_op,
    input  logic                 ex_rd_wen,
    input  rv_mem_pkg::xlen_t    ex_result,
    input  rv_mem_pkg::xlen_t    ex_src2,
    output logic                 ex_ready,
    output logic                 wb_valid,
    output rv_mem_pkg::xlen_t    wb_pc,
    output rv_mem_pkg::inst_t    wb_inst,
    input  logic                 wb_ready,
    output logic                 rf_wen,
    output rv_mem_pkg::reg_idx_t rf_waddr,
    output rv_mem_pkg::xlen_t    rf_wdata,
    input  logic                 fwd_valid,
    input  rv_mem_pkg::inst_t    fwd_inst,
    input  rv_mem_pkg::xlen_t    fwd_wdata,
    output axi_pkg::axi_addr_t   axi_araddr,
    output logic [7:0]           axi_arlen,
    output logic [2:0]           axi_arsize,
    output logic [1:0]           axi_arburst,
    output logic                 axi_arvalid,
    input  logic                 axi_arready,
    input  axi_pkg::axi_data_t   axi_rdata,
    input  logic [1:0]           axi_rresp,
    input  logic                 axi_rlast,
    input  logic                 axi_rvalid,
    output logic                 axi_rready,
    output axi_pkg::axi_addr_t   axi_awaddr,
    output logic [7:0]           axi_awlen,
    output logic [2:0]           axi_awsize,
    output logic [1:0]           axi_awburst,
    output logic                 axi_awvalid,
    input  logic                 axi_awready,
    output axi_pkg::axi_data_t   axi_wdata,
    output axi_pkg::axi_strb_t   axi_wstrb,
    output logic                 axi_wlast,
    output logic                 axi_wvalid,
    input  logic                 axi_wready,
    input  logic [1:0]           axi_bresp,
    input  logic                 axi_bvalid,
    output logic                 axi_bready
);
    import rv_mem_pkg::*;
    import axi_pkg::*;

    logic    st_valid;
    xlen_t   st_pc;
    inst_t   st_inst;
    mem_op_t st_mem_op;
    logic    st_rd_wen;
    xlen_t   st_result;     // alu result, also the memory address
    xlen_t   st_src2;

    // cache request side, named after the dcache ports
    logic      req;
    axi_addr_t addr;
    logic      wr;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      done;
    axi_data_t rdata;

    xlen_t store_src;
    xlen_t load_data;
    logic  blocked;

    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= 1'b0;
        end else if (ex_ready) begin
            st_valid <= ex_valid;   // bubble when ex_valid is low
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready) begin
            st_pc     <= ex_pc;
            st_inst   <= ex_inst;
            st_mem_op <= ex_mem_op;
            st_rd_wen <= ex_rd_wen;
            st_result <= ex_result;
            st_src2   <= ex_src2;
        end
    end

    assign req  = st_valid && (is_load(st_mem_op) || is_store(st_mem_op));
    assign addr = st_result[31:0];
    assign wr   = is_store(st_mem_op);

    assign blocked  = req && !done;
    assign ex_ready = !blocked && wb_ready;
    assign wb_valid = st_valid && !blocked;
    assign wb_pc    = st_valid ? st_pc : '0;
    assign wb_inst  = st_valid ? st_inst : '0;

    assign rf_wen   = wb_valid && st_rd_wen;
    assign rf_waddr = wb_valid ? st_inst[11:7] : '0;
    assign rf_wdata = !wb_valid ? '0 : (is_load(st_mem_op) ? load_data : st_result);

    wb_forward u_wb_forward (
        .mem_inst  (st_inst),
        .fwd_valid (fwd_valid),
        .fwd_inst  (fwd_inst),
        .fwd_wdata (fwd_wdata),
        .src2      (st_src2),
        .store_src (store_src)
    );

    lsu_format u_lsu_format (
        .mem_op     (st_mem_op),
        .addr       (st_result[2:0]),
        .store_src  (store_src),
        .store_data (wdata),
        .store_strb (wstrb),
        .line_data  (rdata),
        .load_data  (load_data)
    );

    dcache #(
        .CACHE_LINES (CACHE_LINES)
    ) u_dcache (.*);

    // a pending cache request holds its level and address until done
    assert property (@(posedge clk) disable iff (rst)
        req && !done |=> req && $stable(addr) && $stable(wr));

endmodule

/* rtl/dcache.sv */
/*
 * direct-mapped write-through data cache
 * 8-byte lines filled by a single axi beat, no allocate on store,
 * one request level in, one done pulse out per served request
 */
`timescale 1ns/1ns

module dcache #(
    parameter int CACHE_LINES = 64      // power of two
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  axi_pkg::axi_addr_t addr,
    input  logic               wr,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    output logic               done,
    output axi_pkg::axi_data_t rdata,
    output axi_pkg::axi_addr_t axi_araddr,
    output logic [7:0]         axi_arlen,
    output logic [2:0]         axi_arsize,
    output logic [1:0]         axi_arburst,
    output logic               axi_arvalid,
    input  logic               axi_arready,
    input  axi_pkg::axi_data_t axi_rdata,
    input  logic [1:0]         axi_rresp,
    input  logic               axi_rlast,
    input  logic               axi_rvalid,
    output logic               axi_rready,
    output axi_pkg::axi_addr_t axi_awaddr,
    output logic [7:0]         axi_awlen,
    output logic [2:0]         axi_awsize,
    output logic [1:0]         axi_awburst,
    output logic               axi_awvalid,
    input  logic               axi_awready,
    output axi_pkg::axi_data_t axi_wdata,
    output axi_pkg::axi_strb_t axi_wstrb,
    output logic               axi_wlast,
    output logic               axi_wvalid,
    input  logic               axi_wready,
    input  logic [1:0]         axi_bresp,
    input  logic               axi_bvalid,
    output logic               axi_bready
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = $bits(axi_addr_t) - 3 - IDX_W;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_ADDR,
        S_READ_DATA,
        S_WRITE_REQ,
        S_WRITE_RESP
    } state_t;

    state_t                 state;
    logic [TAG_W-1:0]       tag_mem [CACHE_LINES];
    axi_data_t              data_mem [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_valid;

    axi_addr_t        req_addr;     // captured when the request starts
    axi_data_t        req_wdata;
    axi_strb_t        req_wstrb;
    logic             aw_done;
    logic             w_done;
    logic             b_seen;       // response taken, done next cycle
    logic             b_err;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] req_tag;
    logic             hit;
    logic             req_hit;

    assign idx     = addr[3 +: IDX_W];
    assign tag     = addr[3 + IDX_W +: TAG_W];
    assign req_idx = req_addr[3 +: IDX_W];
    assign req_tag = req_addr[3 + IDX_W +: TAG_W];
    assign hit     = line_valid[idx] && (tag_mem[idx] == tag);
    assign req_hit = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);

    // load hits answer in the request cycle, stores after the b beat
    assign rdata = data_mem[idx];
    assign done  = (state == S_IDLE && req && !wr && hit) || (state == S_WRITE_RESP && b_seen);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            line_valid <= '0;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            b_seen     <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req && wr) begin
                        state   <= S_WRITE_REQ;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else if (req && !hit) begin
                        state <= S_READ_ADDR;
                    end
                end
                S_READ_ADDR: if (axi_arready) state <= S_READ_DATA;
                S_READ_DATA: begin
                    if (axi_rvalid) begin
                        // a failed fill stays invalid and the load retries
                        line_valid[req_idx] <= axi_rlast && !axi_rresp[1];
                        state               <= S_IDLE;
                    end
                end
                S_WRITE_REQ: begin
                    if (axi_awready) aw_done <= 1'b1;
                    if (axi_wready) w_done <= 1'b1;
                    if ((aw_done || axi_awready) && (w_done || axi_wready)) begin
                        state <= S_WRITE_RESP;
                    end
                end
                S_WRITE_RESP: begin
                    if (b_seen) begin
                        b_seen <= 1'b0;
                        state  <= S_IDLE;
                    end else if (axi_bvalid) begin
                        b_seen <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_wstrb <= wstrb;
        end
        if (state == S_READ_DATA && axi_rvalid) begin
            data_mem[req_idx] <= axi_rdata;
            tag_mem[req_idx]  <= req_tag;
        end
        if (state == S_WRITE_RESP && !b_seen && axi_bvalid) b_err <= axi_bresp[1];
        // write-through hit, merge under strobe once memory took it
        if (state == S_WRITE_RESP && b_seen && req_hit && !b_err) begin
            for (int i = 0; i < 8; i++) begin
                if (req_wstrb[i]) data_mem[req_idx][8*i +: 8] <= req_wdata[8*i +: 8];
            end
        end
    end

    assign axi_araddr  = {req_addr[31:3], 3'b000};    // line aligned
    assign axi_arlen   = 8'd0;
    assign axi_arsize  = AXI_SIZE_8B;
    assign axi_arburst = AXI_BURST_INCR;
    assign axi_arvalid = (state == S_READ_ADDR);
    assign axi_rready  = (state == S_READ_DATA);
    assign axi_awaddr  = {req_addr[31:3], 3'b000};
    assign axi_awlen   = 8'd0;
    assign axi_awsize  = AXI_SIZE_8B;
    assign axi_awburst = AXI_BURST_INCR;
    assign axi_awvalid = (state == S_WRITE_REQ) && !aw_done;
    assign axi_wdata   = req_wdata;
    assign axi_wstrb   = req_wstrb;
    assign axi_wlast   = 1'b1;
    assign axi_wvalid  = (state == S_WRITE_REQ) && !w_done;
    assign axi_bready  = (state == S_WRITE_RESP) && !b_seen;

    // address valids hold with a stable address until accepted
    assert property (@(posedge clk) disable iff (rst)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr));
    assert property (@(posedge clk) disable iff (rst)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr));

endmodule

/* rtl/wb_forward.sv */
/*
 * store data forwarding
 * replaces rs2 of the instruction in the memory stage with the value
 * being written back when the writeback instruction targets that register
 */
`timescale 1ns/1ns

module wb_forward (
    input  rv_mem_pkg::inst_t mem_inst,
    input  logic              fwd_valid,
    input  rv_mem_pkg::inst_t fwd_inst,
    input  rv_mem_pkg::xlen_t fwd_wdata,
    input  rv_mem_pkg::xlen_t src2,
    output rv_mem_pkg::xlen_t store_src
);
    import rv_mem_pkg::*;

    // major opcodes that write rd
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    reg_idx_t fwd_rd;
    reg_idx_t rs2;
    logic     fwd_writes;

    assign fwd_rd = fwd_inst[11:7];
    assign rs2    = mem_inst[24:20];

    always_comb begin
        case (fwd_inst[6:0])
            OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_OP_IMM_32,
            OPC_OP, OPC_LUI, OPC_OP_32: fwd_writes = 1'b1;
            default:                    fwd_writes = 1'b0;
        endcase
    end

    // x0 never forwards
    assign store_src = (fwd_valid && fwd_writes && fwd_rd == rs2 && rs2 != '0)
                     ? fwd_wdata : src2;

endmodule

/* rtl/lsu_format.sv */
/*
 * load/store formatter
 * places store data and strobe into the byte lanes of a doubleword and
 * picks a loaded lane out of the line, sign or zero extending it
 */
`timescale 1ns/1ns

module lsu_format (
    input  rv_mem_pkg::mem_op_t mem_op,
    input  logic [2:0]          addr,       // byte offset inside the doubleword
    input  rv_mem_pkg::xlen_t   store_src,
    output axi_pkg::axi_data_t  store_data,
    output axi_pkg::axi_strb_t  store_strb,
    input  axi_pkg::axi_data_t  line_data,
    output rv_mem_pkg::xlen_t   load_data
);
    import rv_mem_pkg::*;
    import axi_pkg::*;

    axi_data_t lane;    // addressed byte moved down to bit 0

    assign lane = line_data >> {addr, 3'b000};

    // replicating the source puts it in every lane, the strobe picks one
    always_comb begin
        case (mem_op)
            MEM_SB: begin
                store_data = {8{store_src[7:0]}};
                store_strb = 8'h01 << addr;
            end
            MEM_SH: begin
                store_data = {4{store_src[15:0]}};
                store_strb = 8'h03 << {addr[2:1], 1'b0};   // halfword aligned only
            end
            MEM_SW: begin
                store_data = {2{store_src[31:0]}};
                store_strb = 8'h0f << {addr[2], 2'b00};
            end
            MEM_SD: begin
                store_data = store_src;
                store_strb = 8'hff;
            end
            default: begin
                store_data = '0;
                store_strb = '0;
            end
        endcase
    end

    always_comb begin
        case (mem_op)
            MEM_LB:  load_data = {{56{lane[7]}}, lane[7:0]};
            MEM_LBU: load_data = {56'b0, lane[7:0]};
            MEM_LH:  load_data = {{48{lane[15]}}, lane[15:0]};
            MEM_LHU: load_data = {48'b0, lane[15:0]};
            MEM_LW:  load_data = {{32{lane[31]}}, lane[31:0]};
            MEM_LWU: load_data = {32'b0, lane[31:0]};
            MEM_LD:  load_data = line_data;
            default: load_data = '0;
        endcase
    end

endmodule

/* rtl/axi_pkg.sv */
/*
 * axi bus types and codes
 * 32-bit address, 64-bit data, byte strobe and the fixed burst fields
 * used by the data cache master port
 */
package axi_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [7:0]  axi_strb_t;

    // single 8-byte beat per transfer
    localparam logic [2:0] AXI_SIZE_8B    = 3'd3;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

endpackage

/* rtl/rv_mem_pkg.sv */
/*
 * rv64 memory stage types
 * data word, instruction word, register index and the memory operation
 * carried from execute, with helpers to classify the operation
 */
package rv_mem_pkg;

    typedef logic [63:0] xlen_t;    // data or address word
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // decoded in execute, one value per load/store flavour
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LD,
        MEM_LBU,
        MEM_LHU,
        MEM_LWU,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SD
    } mem_op_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
    endfunction

endpackage
